/* hdl/rst_ctrl_pkg.sv */
package rst_ctrl_pkg;

   //******************************
   // Sequencer states
   //******************************
   typedef enum logic [2:0]
   {
      ST_WAIT_LOCK    = 3'd0, // PLL lock and config done
      ST_COLD_ASSERT  = 3'd1, // Cold request low, wait for ack_n low
      ST_COLD_RELEASE = 3'd2, // Cold request high, wait for ack_n high
      ST_HOLD         = 3'd3, // Domain resets held by timer
      ST_RUN          = 3'd4,
      ST_WARM_ASSERT  = 3'd5, // Warm request low, wait for ack_n low
      ST_WARM_RELEASE = 3'd6, // Warm request high, wait for ack_n and link
      ST_WARM_WAIT    = 3'd7  // System domain held by timer
   } rst_state_e;

   //******************************
   // Reset timing
   //******************************

   // Cycles the domain resets stay asserted after a completed handshake
   localparam int HOLD_CYCLES = 16;

   // Hold counter width, must hold HOLD_CYCLES
   localparam int HOLD_CNT_W  = 5;

   // Flip-flops per asynchronous status input
   localparam int SYNC_STAGES = 2;

endpackage : rst_ctrl_pkg

/* hdl/rst_status_if.sv */
// Synchronized status seen by the sequencer, all plain levels
interface rst_status_if;

   logic pll_locked;
   logic init_done;   // Active high, already inverted
   logic link_rst;    // PCIe reset status
   logic cold_ack_n;
   logic warm_ack_n;

   modport src
   (
      output pll_locked, init_done, link_rst, cold_ack_n, warm_ack_n
   );

   modport dst
   (
      input  pll_locked, init_done, link_rst, cold_ack_n, warm_ack_n
   );

endinterface : rst_status_if

/* hdl/rst_cmd_if.sv */
// Reset commands, active high, from sequencer to output registers
interface rst_cmd_if;

   logic hold_csr;  // CSR domain and power good
   logic hold_sys;  // System domain
   logic cold_req;  // PCIe cold reset request
   logic warm_req;  // PCIe warm reset request

   modport fsm
   (
      output hold_csr, hold_sys, cold_req, warm_req
   );

   modport out
   (
      input  hold_csr, hold_sys, cold_req, warm_req
   );

endinterface : rst_cmd_if

/* hdl/rst_input_sync.sv */
module rst_input_sync
   import rst_ctrl_pkg::*;
(
   input  logic         clk_sys,
   input  logic         i_arst_n,
   input  logic         i_pll_locked,
   input  logic         i_ninit_done,
   input  logic         i_pcie_reset_status,
   input  logic         i_pcie_cold_rst_ack_n,
   input  logic         i_pcie_warm_rst_ack_n,
   rst_status_if.src    o_status
);

   // Bit order {warm_ack_n, cold_ack_n, reset_status, ninit_done, pll_locked}
   logic [4:0] sync_q [SYNC_STAGES];

   always_ff @(posedge clk_sys or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         // Unlocked, not initialized, no link reset, both acks idle
         for (int i = 0; i < SYNC_STAGES; i++)
         begin
            sync_q[i] <= 5'b11010;
         end
      end
      else
      begin
         sync_q[0] <= {i_pcie_warm_rst_ack_n,
                       i_pcie_cold_rst_ack_n,
                       i_pcie_reset_status,
                       i_ninit_done,
                       i_pll_locked};
         for (int i = 1; i < SYNC_STAGES; i++)
         begin
            sync_q[i] <= sync_q[i-1];
         end
      end
   end

   assign o_status.pll_locked = sync_q[SYNC_STAGES-1][0];
   assign o_status.init_done  = ~sync_q[SYNC_STAGES-1][1]; // Config done, now active high
   assign o_status.link_rst   = sync_q[SYNC_STAGES-1][2];
   assign o_status.cold_ack_n = sync_q[SYNC_STAGES-1][3];
   assign o_status.warm_ack_n = sync_q[SYNC_STAGES-1][4];

endmodule : rst_input_sync

/* hdl/rst_hold_timer.sv */
module rst_hold_timer
   import rst_ctrl_pkg::*;
(
   input  logic clk_sys,
   input  logic i_arst_n,
   input  logic i_start,
   output logic o_done
);

   logic [HOLD_CNT_W-1:0] cnt_q;

   // Start to done is HOLD_CYCLES clocks, done then stays up
   always_ff @(posedge clk_sys or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         cnt_q  <= '0;
         o_done <= 1'b0;
      end
      else if (i_start)
      begin
         cnt_q  <= HOLD_CNT_W'(HOLD_CYCLES);
         o_done <= 1'b0;
      end
      else if (cnt_q != '0)
      begin
         cnt_q  <= cnt_q - HOLD_CNT_W'(1);
         o_done <= (cnt_q == HOLD_CNT_W'(1)); // Last count
      end
   end

endmodule : rst_hold_timer

/* hdl/rst_seq_fsm.sv */
module rst_seq_fsm
   import rst_ctrl_pkg::*;
(
   input  logic         clk_sys,
   input  logic         i_arst_n,
   input  logic         i_timer_done,
   output logic         o_timer_start,
   rst_status_if.dst    i_status,
   rst_cmd_if.fsm       o_cmd
);

   rst_state_e state_q;
   rst_state_e state_d;

   //******************************
   // State register
   //******************************
   always_ff @(posedge clk_sys or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         state_q <= ST_WAIT_LOCK;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   //******************************
   // Next state
   //******************************
   always_comb
   begin
      state_d       = state_q;
      o_timer_start = 1'b0;

      unique case (state_q)
         ST_WAIT_LOCK:
         begin
            // Only start from an idle handshake
            if (i_status.pll_locked && i_status.init_done &&
                i_status.cold_ack_n && i_status.warm_ack_n)
            begin
               state_d = ST_COLD_ASSERT;
            end
         end
         ST_COLD_ASSERT:
         begin
            if (!i_status.cold_ack_n)
            begin
               state_d = ST_COLD_RELEASE;
            end
         end
         ST_COLD_RELEASE:
         begin
            if (i_status.cold_ack_n)
            begin
               o_timer_start = 1'b1; // Handshake done
               state_d       = ST_HOLD;
            end
         end
         ST_HOLD:
         begin
            if (i_timer_done)
            begin
               state_d = ST_RUN;
            end
         end
         ST_RUN:
         begin
            if (i_status.link_rst && i_status.warm_ack_n)
            begin
               state_d = ST_WARM_ASSERT;
            end
         end
         ST_WARM_ASSERT:
         begin
            if (!i_status.warm_ack_n)
            begin
               state_d = ST_WARM_RELEASE;
            end
         end
         ST_WARM_RELEASE:
         begin
            // Wait for ack_n back high and link reset gone
            if (i_status.warm_ack_n && !i_status.link_rst)
            begin
               o_timer_start = 1'b1;
               state_d       = ST_WARM_WAIT;
            end
         end
         ST_WARM_WAIT:
         begin
            if (i_timer_done)
            begin
               state_d = ST_RUN;
            end
         end
         default:
         begin
            state_d = ST_WAIT_LOCK;
         end
      endcase

      // Lock loss wins over any wait
      if (!i_status.pll_locked)
      begin
         state_d       = ST_WAIT_LOCK;
         o_timer_start = 1'b0;
      end
   end

   //******************************
   // Commands decoded from state
   //******************************
   always_comb
   begin
      o_cmd.hold_csr = (state_q != ST_RUN) && (state_q != ST_WARM_ASSERT) &&
                       (state_q != ST_WARM_RELEASE) && (state_q != ST_WARM_WAIT);
      o_cmd.hold_sys = (state_q != ST_RUN);
      o_cmd.cold_req = (state_q == ST_COLD_ASSERT);
      o_cmd.warm_req = (state_q == ST_WARM_ASSERT);
   end

endmodule : rst_seq_fsm

/* hdl/rst_out_stage.sv */
module rst_out_stage
(
   input  logic      clk_sys,
   input  logic      i_arst_n,
   rst_cmd_if.out    i_cmd,
   output logic      o_rst_n_sys,
   output logic      o_rst_n_csr,
   output logic      o_pwr_good_n,
   output logic      o_pcie_cold_rst_n,
   output logic      o_pcie_warm_rst_n
);

   logic sys_rel_q; // First stage of the system release delay

   always_ff @(posedge clk_sys or negedge i_arst_n)
   begin
      if (!i_arst_n)
      begin
         sys_rel_q         <= 1'b0;
         o_rst_n_sys       <= 1'b0;
         o_rst_n_csr       <= 1'b0;
         o_pwr_good_n      <= 1'b0;
         o_pcie_cold_rst_n <= 1'b1; // Requests idle high
         o_pcie_warm_rst_n <= 1'b1;
      end
      else
      begin
         sys_rel_q         <= ~i_cmd.hold_sys;
         // Assert at once, release one cycle after the CSR domain
         o_rst_n_sys       <= ~i_cmd.hold_sys & sys_rel_q;
         o_rst_n_csr       <= ~i_cmd.hold_csr;
         o_pwr_good_n      <= ~i_cmd.hold_csr; // Follows CSR domain
         o_pcie_cold_rst_n <= ~i_cmd.cold_req;
         o_pcie_warm_rst_n <= ~i_cmd.warm_req;
      end
   end

endmodule : rst_out_stage

/* hdl/rst_ctrl_top.sv */
module rst_ctrl_top
(
   input  logic clk_sys,
   input  logic i_arst_n,
   input  logic i_pll_locked,
   input  logic i_ninit_done,
   input  logic i_pcie_reset_status,
   input  logic i_pcie_cold_rst_ack_n,
   input  logic i_pcie_warm_rst_ack_n,
   output logic o_rst_n_sys,
   output logic o_rst_n_csr,
   output logic o_pwr_good_n,
   output logic o_pcie_cold_rst_n,
   output logic o_pcie_warm_rst_n
);

   logic timer_start;
   logic timer_done;

   rst_status_if status_if ();
   rst_cmd_if    cmd_if ();

   //******************************
   // Status synchronizer
   //******************************
   rst_input_sync rst_input_sync (
      .clk_sys               (clk_sys              ),
      .i_arst_n              (i_arst_n             ),
      .i_pll_locked          (i_pll_locked         ),
      .i_ninit_done          (i_ninit_done         ),
      .i_pcie_reset_status   (i_pcie_reset_status  ),
      .i_pcie_cold_rst_ack_n (i_pcie_cold_rst_ack_n),
      .i_pcie_warm_rst_ack_n (i_pcie_warm_rst_ack_n),
      .o_status              (status_if            )
   );

   //******************************
   // Sequencer and hold timer
   //******************************
   rst_seq_fsm rst_seq_fsm (
      .clk_sys       (clk_sys    ),
      .i_arst_n      (i_arst_n   ),
      .i_timer_done  (timer_done ),
      .o_timer_start (timer_start),
      .i_status      (status_if  ),
      .o_cmd         (cmd_if     )
   );

   rst_hold_timer rst_hold_timer (
      .clk_sys  (clk_sys    ),
      .i_arst_n (i_arst_n   ),
      .i_start  (timer_start),
      .o_done   (timer_done )
   );

   //******************************
   // Output registers
   //******************************
   rst_out_stage rst_out_stage (
      .clk_sys           (clk_sys          ),
      .i_arst_n          (i_arst_n         ),
      .i_cmd             (cmd_if           ),
      .o_rst_n_sys       (o_rst_n_sys      ), // System domain, after CSR
      .o_rst_n_csr       (o_rst_n_csr      ),
      .o_pwr_good_n      (o_pwr_good_n     ),
      .o_pcie_cold_rst_n (o_pcie_cold_rst_n),
      .o_pcie_warm_rst_n (o_pcie_warm_rst_n)
   );

endmodule : rst_ctrl_top

/* verif/tb_pcie_rst_model.sv */
module tb_pcie_rst_model
(
   input  logic clk_sys,
   input  logic i_cold_rst_n,
   input  logic i_warm_rst_n,
   output logic o_cold_rst_ack_n,
   output logic o_warm_rst_ack_n
);

   logic [7:0] lfsr_q = 8'd27;

   // Taps 8,6,5,4 for a maximal length sequence
   function automatic logic [7:0] lfsr_step(input logic [7:0] s);
      return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
   endfunction

   // Four bits, one step each, zero maps to 1
   task automatic draw_delay(output int cycles);
      logic [3:0] bits;
      for (int i = 0; i < 4; i++)
      begin
         lfsr_q  = lfsr_step(lfsr_q);
         bits[i] = lfsr_q[0];
      end
      cycles = (bits == 4'd0) ? 1 : int'(bits);
   endtask

   //******************************
   // Ack follows its request
   //******************************
   initial
   begin
      int cycles;
      o_cold_rst_ack_n = 1'b1;
      forever
      begin
         @(posedge clk_sys);
         if (i_cold_rst_n != o_cold_rst_ack_n)
         begin
            draw_delay(cycles);
            repeat (cycles - 1) @(posedge clk_sys);
            #2 o_cold_rst_ack_n = i_cold_rst_n; // Request may have returned meanwhile
         end
      end
   end

   initial
   begin
      int cycles;
      o_warm_rst_ack_n = 1'b1;
      forever
      begin
         @(posedge clk_sys);
         if (i_warm_rst_n != o_warm_rst_ack_n)
         begin
            draw_delay(cycles);
            repeat (cycles - 1) @(posedge clk_sys);
            #2 o_warm_rst_ack_n = i_warm_rst_n;
         end
      end
   end

endmodule : tb_pcie_rst_model

/* verif/tb_rst_ctrl.sv */
module tb_rst_ctrl
   import rst_ctrl_pkg::*;
();

   localparam int TIMEOUT_CYCLES = 5 * (4 * 15 + HOLD_CYCLES + 20);

   logic clk_sys;
   logic i_arst_n;
   logic i_pll_locked;
   logic i_ninit_done;
   logic i_pcie_reset_status;
   logic i_pcie_cold_rst_ack_n;
   logic i_pcie_warm_rst_ack_n;
   logic o_rst_n_sys;
   logic o_rst_n_csr;
   logic o_pwr_good_n;
   logic o_pcie_cold_rst_n;
   logic o_pcie_warm_rst_n;
   logic [4:0] outs; // {sys, csr, pwr_good, cold, warm}

   int errors = 0;
   int err_mark = 0;
   int tests = 0;
   int cycle_cnt = 0;
   int notready_cnt = 0;       // Cycles with lock low or config pending
   int since_cold_ack = 0;
   int since_warm_ack = 1000;
   int since_status_fall = 1000;
   int status_age = 1000;
   logic cold_done = 1'b0;     // Cold handshake completed since lock came back
   logic warm_done = 1'b1;     // Warm handshake completed since the last link reset
   logic sys_at_status = 1'b0;
   logic cold_ack_q = 1'b1;
   logic warm_ack_q = 1'b1;
   logic status_q = 1'b0;
   logic [7:0] lock_hist = '0;
   logic lock_steady;

   assign outs        = {o_rst_n_sys, o_rst_n_csr, o_pwr_good_n,
                         o_pcie_cold_rst_n, o_pcie_warm_rst_n};
   assign lock_steady = &lock_hist;

   rst_ctrl_top i_rst_ctrl_top (.*);

   tb_pcie_rst_model pcie_model (
      .clk_sys          (clk_sys              ),
      .i_cold_rst_n     (o_pcie_cold_rst_n    ),
      .i_warm_rst_n     (o_pcie_warm_rst_n    ),
      .o_cold_rst_ack_n (i_pcie_cold_rst_ack_n),
      .o_warm_rst_ack_n (i_pcie_warm_rst_ack_n)
   );

   initial
   begin
      clk_sys = 1'b0;
      forever #20 clk_sys = ~clk_sys;
   end

   function automatic int sat_inc(input int v);
      return (v >= 1000) ? v : v + 1;
   endfunction

   task automatic report_value(input string name, input int got, input int exp);
      errors++;
      $display("FAILED %s = 0x%0h, expected 0x%0h at cycle %0d", name, got, exp, cycle_cnt);
   endtask

   task automatic report_rule(input string what);
      errors++;
      $display("Error at cycle %0d: %s", cycle_cnt, what);
   endtask

   //******************************
   // Reference timing trackers
   //******************************
   always @(posedge clk_sys)
   begin
      cycle_cnt         <= cycle_cnt + 1;
      lock_hist         <= {lock_hist[6:0], i_pll_locked};
      notready_cnt      <= (i_pll_locked && !i_ninit_done) ? 0 : sat_inc(notready_cnt);
      cold_ack_q        <= i_pcie_cold_rst_ack_n;
      warm_ack_q        <= i_pcie_warm_rst_ack_n;
      status_q          <= i_pcie_reset_status;
      since_cold_ack    <= (i_pcie_cold_rst_ack_n && !cold_ack_q) ? 0 : sat_inc(since_cold_ack);
      since_warm_ack    <= (i_pcie_warm_rst_ack_n && !warm_ack_q) ? 0 : sat_inc(since_warm_ack);
      since_status_fall <= (!i_pcie_reset_status && status_q) ? 0 : sat_inc(since_status_fall);
      status_age        <= (i_pcie_reset_status && !status_q) ? 0 : sat_inc(status_age);
      if (i_pcie_reset_status && !status_q)
         sys_at_status <= o_rst_n_sys;
      if (i_pcie_cold_rst_ack_n != cold_ack_q)
         cold_done <= i_pcie_cold_rst_ack_n;
      if (!i_pll_locked)
         cold_done <= 1'b0; // A fresh cold handshake is due after lock loss
      if (i_pcie_reset_status && !status_q)
         warm_done <= 1'b0;
      if (i_pcie_warm_rst_ack_n != warm_ack_q)
         warm_done <= i_pcie_warm_rst_ack_n;
   end

   //******************************
   // Checks
   //******************************
   assert property (@(posedge clk_sys) (cycle_cnt != 0 && !i_arst_n) |-> outs == 5'b00011)
      else report_value("outs", int'($sampled(outs)), 'h03);
   // Outputs settle four cycles after lock loss or pending config
   assert property (@(posedge clk_sys) disable iff (!i_arst_n)
                    notready_cnt >= 4 |-> outs == 5'b00011)
      else report_value("outs", int'($sampled(outs)), 'h03);
   assert property (@(posedge clk_sys) disable iff (!i_arst_n)
                    $fell(o_pcie_cold_rst_n) |-> $past(i_pcie_cold_rst_ack_n))
      else report_rule("cold request fell before its ack_n returned high");
   assert property (@(posedge clk_sys) disable iff (!i_arst_n)
                    $rose(o_pcie_cold_rst_n) && lock_steady |-> !$past(i_pcie_cold_rst_ack_n))
      else report_rule("cold request rose before its ack_n went low");
   assert property (@(posedge clk_sys) disable iff (!i_arst_n)
                    $fell(o_pcie_warm_rst_n) |-> $past(i_pcie_warm_rst_ack_n))
      else report_rule("warm request fell before its ack_n returned high");
   assert property (@(posedge clk_sys) disable iff (!i_arst_n)
                    $rose(o_pcie_warm_rst_n) && lock_steady |-> !$past(i_pcie_warm_rst_ack_n))
      else report_rule("warm request rose before its ack_n went low");
   assert property (@(posedge clk_sys) disable iff (!i_arst_n)
                    o_pcie_cold_rst_n || o_pcie_warm_rst_n)
      else report_rule("cold and warm requests are low together");
   assert property (@(posedge clk_sys) disable iff (!i_arst_n)
                    $rose(o_rst_n_csr) |-> cold_done && since_cold_ack >= HOLD_CYCLES)
      else report_rule("CSR domain released before cold handshake and hold time");
   assert property (@(posedge clk_sys) disable iff (!i_arst_n)
                    o_pwr_good_n == o_rst_n_csr)
      else report_value("o_pwr_good_n", int'($sampled(o_pwr_good_n)),
                        int'($sampled(o_rst_n_csr)));
   assert property (@(posedge clk_sys) disable iff (!i_arst_n)
                    $rose(o_rst_n_csr) |=> $rose(o_rst_n_sys))
      else report_rule("system domain not released one cycle after CSR domain");
   assert property (@(posedge clk_sys) disable iff (!i_arst_n)
                    $fell(o_rst_n_csr) |-> !lock_steady)
      else report_rule("CSR domain reset without a loss of PLL lock");
   assert property (@(posedge clk_sys) disable iff (!i_arst_n)
                    (status_age == 4 && sys_at_status) |-> !o_rst_n_sys)
      else report_value("o_rst_n_sys", int'($sampled(o_rst_n_sys)), 'h0);
   assert property (@(posedge clk_sys) disable iff (!i_arst_n)
                    $rose(o_rst_n_sys) |-> warm_done && since_warm_ack >= HOLD_CYCLES &&
                                           since_status_fall >= HOLD_CYCLES)
      else report_rule("system domain released before warm handshake and hold time");

   always @(posedge clk_sys)
   begin
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Done: errors found");
         $finish;
      end
   end

   //******************************
   // Stimulus
   //******************************
   task automatic step(input int n);
      repeat (n) @(posedge clk_sys);
      #2; // Inputs change just after the edge
   endtask

   task automatic wait_sys(input logic level);
      while (o_rst_n_sys !== level)
         step(1);
   endtask

   task automatic finish_test(input string name);
      tests++;
      $display("Test %0d %s: %0d errors", tests, name, errors - err_mark);
      err_mark = errors;
   endtask

   initial
   begin
      i_arst_n            = 1'b0;
      i_pll_locked        = 1'b0;
      i_ninit_done        = 1'b1;
      i_pcie_reset_status = 1'b0;
      step(4);
      i_arst_n = 1'b1;
      step(3);
      i_pll_locked = 1'b1; // Locked but config still pending
      step(8);
      i_ninit_done = 1'b0;
      wait_sys(1'b1);
      finish_test("cold start");

      step(5);
      i_pcie_reset_status = 1'b1;
      step(6);
      i_pcie_reset_status = 1'b0;
      wait_sys(1'b1);
      finish_test("warm reset short pulse");

      step(5);
      i_pll_locked = 1'b0;
      step(6);
      i_pll_locked = 1'b1;
      wait_sys(1'b1);
      finish_test("lock loss in run");

      step(5);
      i_pll_locked = 1'b0;
      step(6);
      i_pll_locked = 1'b1;
      while (o_pcie_cold_rst_n)
         step(1);
      step(1);
      i_pll_locked = 1'b0; // Mid handshake
      step(6);
      i_pll_locked = 1'b1;
      wait_sys(1'b1);
      finish_test("lock loss in handshake");

      step(5);
      i_pcie_reset_status = 1'b1;
      step(30);
      i_pcie_reset_status = 1'b0;
      wait_sys(1'b1);
      finish_test("warm reset long pulse");

      step(5);
      $display("Summary: %0d tests, %0d errors", tests, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule : tb_rst_ctrl

/* sim.f */
hdl/rst_ctrl_pkg.sv
hdl/rst_status_if.sv
hdl/rst_cmd_if.sv
hdl/rst_input_sync.sv
hdl/rst_hold_timer.sv
hdl/rst_seq_fsm.sv
hdl/rst_out_stage.sv
hdl/rst_ctrl_top.sv
verif/tb_pcie_rst_model.sv
verif/tb_rst_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the reset controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_rst_ctrl

./obj_dir/Vtb_rst_ctrl > sim.log 2>&1
cat sim.log

# The testbench decides pass or fail
if grep -q "Done: errors found" sim.log; then
   exit 1
fi
grep -q "Done: no errors" sim.log
